// ==== src/board_pkg.sv ====
// Shared sample, level and LED types for the audio board shell
// Imported by the RTL blocks and the testbench

`default_nettype none

package board_pkg;

    //------------------------------------------------------------------------
    // Audio samples

    // Raw sample from the INMP441, left-justified two's complement
    typedef logic signed [23:0] mic_sample_t;

    // Sample sent to the DAC, top 16 bits of a mic sample
    typedef logic signed [15:0] audio_sample_t;

    // Volume attenuation as a right-shift count, 0 is full volume
    typedef logic        [ 2:0] atten_t;

    //------------------------------------------------------------------------
    // Level meter

    // Magnitude of the top byte of a sample, 0 .. 127
    typedef logic        [ 6:0] level_t;

    // Thermometer pattern on the board LEDs, bit 7 is the clip light
    typedef logic        [ 7:0] led_bar_t;

endpackage

`default_nettype wire

// ==== src/slow_clk_gen.sv ====
// Slow square wave made from the main clock
// Used as the decay tick of the level meter

`timescale 1ns/10ps
`default_nettype none

module slow_clk_gen
#(
    parameter int fast_clk_mhz = 50,
    parameter int slow_clk_hz  = 1
)
(
    input  logic clk,
    input  logic rst,
    output logic slow_clk
);

    // Main clock cycles per half period of slow_clk
    localparam int half_period = fast_clk_mhz * 1_000_000 / (2 * slow_clk_hz);
    localparam int w_cnt       = half_period > 1 ? $clog2(half_period) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt      <= '0;
            slow_clk <= 1'b0;
        end
        else if (cnt == w_cnt'(half_period - 1))
        begin
            cnt      <= '0;
            slow_clk <= ~slow_clk;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/inmp441_mic_i2s_receiver.sv ====
// I2S master for the INMP441 microphone
// Drives sck and ws and returns each left-channel 24-bit sample with a strobe

`timescale 1ns/10ps
`default_nettype none

module inmp441_mic_i2s_receiver
    import board_pkg::*;
#(
    parameter int clk_mhz = 50
)
(
    input  logic        clk,
    input  logic        rst,
    output logic        sck,
    output logic        ws,
    input  logic        sd,
    output mic_sample_t value,
    output logic        value_valid
);

    // Clock cycles per half period of sck, about 3 MHz
    localparam int sck_half = clk_mhz / 6 > 0 ? clk_mhz / 6 : 1;
    localparam int w_div    = sck_half > 1 ? $clog2(sck_half) : 1;

    logic [w_div - 1:0] div_cnt;
    logic               div_wrap;
    logic [        5:0] bit_cnt;
    logic [       22:0] shift_reg;

    assign div_wrap = (div_cnt == w_div'(sck_half - 1));

    // 64 sck periods per frame, low half is the left channel
    assign ws = bit_cnt[5];

    //------------------------------------------------------------------------
    // sck and frame position

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end
        else if (div_wrap)
        begin
            div_cnt <= '0;
            sck     <= ~sck;

            // Frame position advances on the falling edge
            if (sck)
                bit_cnt <= bit_cnt + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Capture on rising edges, MSB arrives one sck after ws falls

    always_ff @(posedge clk)
    begin
        if (div_wrap && !sck && bit_cnt >= 6'd1 && bit_cnt <= 6'd24)
            shift_reg <= {shift_reg[21:0], sd};
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            value       <= '0;
            value_valid <= 1'b0;
        end
        else
        begin
            value_valid <= 1'b0;

            if (div_wrap && !sck && bit_cnt == 6'd24)
            begin
                value       <= {shift_reg, sd};
                value_valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/i2s_audio_out.sv ====
// I2S transmitter for a stereo DAC
// Makes mclk, bclk and lrclk and sends the same 16-bit word on both channels

`timescale 1ns/10ps
`default_nettype none

module i2s_audio_out
    import board_pkg::*;
#(
    parameter int clk_mhz = 50
)
(
    input  logic          clk,
    input  logic          reset,
    input  audio_sample_t data_in,
    output logic          mclk,
    output logic          bclk,
    output logic          sdata,
    output logic          lrclk
);

    // Clock cycles per half period of mclk, aiming at about 12.5 MHz
    localparam int mclk_half = (clk_mhz + 24) / 25 > 0 ? (clk_mhz + 24) / 25 : 1;
    localparam int w_pre     = mclk_half > 1 ? $clog2(mclk_half) : 1;

    logic [w_pre - 1:0] pre_cnt;
    logic               tick;
    logic [        7:0] phase;
    logic               bclk_fall;
    logic               lr_edge;
    audio_sample_t      cur_word;
    audio_sample_t      shift_reg;

    //------------------------------------------------------------------------
    // Clock divider
    // One phase step per mclk half period, 8 steps per bclk, 256 per frame

    assign tick = (pre_cnt == w_pre'(mclk_half - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pre_cnt <= '0;
            phase   <= '0;
        end
        else if (tick)
        begin
            pre_cnt <= '0;
            phase   <= phase + 1'b1;
        end
        else
        begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    assign mclk  = phase[0];
    assign bclk  = phase[2];
    assign lrclk = phase[7];

    // Falling edge of bclk, and lrclk toggling on the same edge
    assign bclk_fall = tick && phase[2:0] == 3'b111;
    assign lr_edge   = bclk_fall && phase[6:3] == 4'b1111;

    //------------------------------------------------------------------------
    // Serializer
    // sdata still shows the drained register at the lrclk edge, so the MSB
    // follows one bclk later

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cur_word  <= '0;
            shift_reg <= '0;
            sdata     <= 1'b0;
        end
        else if (bclk_fall)
        begin
            sdata <= shift_reg[15];

            if (lr_edge && lrclk)
            begin
                // Start of a frame, left half next
                cur_word  <= data_in;
                shift_reg <= data_in;
            end
            else if (lr_edge)
            begin
                shift_reg <= cur_word;
            end
            else
            begin
                shift_reg <= {shift_reg[14:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/lab_top.sv ====
// Lab design: microphone loopback with key volume control and an LED level meter
// key[0] turns the volume down, key[1] turns it up

`timescale 1ns/10ps
`default_nettype none

module lab_top
    import board_pkg::*;
(
    input  logic          clk,
    input  logic          slow_clk,
    input  logic          rst,
    input  logic [1:0]    key,
    input  mic_sample_t   mic,
    input  logic          mic_valid,
    output audio_sample_t sound,
    output led_bar_t      led
);

    logic [1:0]    key_sync1;
    logic [1:0]    key_sync2;
    logic [1:0]    key_prev;
    logic [1:0]    key_press;
    atten_t        atten;
    audio_sample_t mic_top;
    level_t        level;
    level_t        peak;
    logic          slow_prev;
    logic          slow_rise;

    //------------------------------------------------------------------------
    // Key synchronizer and rising edge detect

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            key_sync1 <= '0;
            key_sync2 <= '0;
            key_prev  <= '0;
        end
        else
        begin
            key_sync1 <= key;
            key_sync2 <= key_sync1;
            key_prev  <= key_sync2;
        end
    end

    assign key_press = key_sync2 & ~key_prev;

    always_ff @(posedge clk)
    begin
        if (rst)
            atten <= '0;
        else if (key_press[0] && atten != 3'd7)
            atten <= atten + 1'b1;
        else if (key_press[1] && atten != 3'd0)
            atten <= atten - 1'b1;
    end

    //------------------------------------------------------------------------
    // Attenuated loopback

    assign mic_top = mic[23:8];

    always_ff @(posedge clk)
    begin
        if (rst)
            sound <= '0;
        else if (mic_valid)
            sound <= mic_top >>> atten;
    end

    //------------------------------------------------------------------------
    // Peak level meter

    // Ones' complement keeps -128 at 127 and fits in 7 bits
    assign level = mic[23] ? ~mic[22:16] : mic[22:16];

    assign slow_rise = slow_clk & ~slow_prev;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            slow_prev <= 1'b0;
            peak      <= '0;
        end
        else
        begin
            slow_prev <= slow_clk;

            if (slow_rise)
                peak <= level;
            else if (mic_valid && level > peak)
                peak <= level;
        end
    end

    always_comb
    begin
        for (int i = 0; i < 7; i++)
            led[i] = (peak >= level_t'(1 << i));

        led[7] = (peak == 7'd127);
    end

endmodule

`default_nettype wire

// ==== src/board_specific_top.sv ====
// Board wrapper around the lab design
// Reset comes from key[2], microphone and DAC sit on dedicated pins

`timescale 1ns/10ps
`default_nettype none

module board_specific_top
    import board_pkg::*;
#(
    parameter int clk_mhz     = 50,
    parameter int slow_clk_hz = 1
)
(
    input  wire       clk,
    input  wire [2:0] key,

    input  wire       mic_sd,
    output wire       mic_sck,
    output wire       mic_ws,

    output wire       i2s_mclk,
    output wire       i2s_bclk,
    output wire       i2s_lrclk,
    output wire       i2s_sdata,

    output wire [7:0] led
);

    //------------------------------------------------------------------------

    // Top key doubles as the board reset
    wire           rst = key[2];

    wire           slow_clk;
    mic_sample_t   mic;
    wire           mic_valid;
    audio_sample_t sound;

    //------------------------------------------------------------------------

    slow_clk_gen
    #(
        .fast_clk_mhz ( clk_mhz     ),
        .slow_clk_hz  ( slow_clk_hz )
    )
    i_slow_clk_gen
    (
        .clk          ( clk         ),
        .rst          ( rst         ),
        .slow_clk     ( slow_clk    )
    );

    //------------------------------------------------------------------------

    // INMP441 lr, GND and VCC are strapped on the board
    inmp441_mic_i2s_receiver
    #(
        .clk_mhz     ( clk_mhz   )
    )
    i_microphone
    (
        .clk         ( clk       ),
        .rst         ( rst       ),
        .sck         ( mic_sck   ),
        .ws          ( mic_ws    ),
        .sd          ( mic_sd    ),
        .value       ( mic       ),
        .value_valid ( mic_valid )
    );

    //------------------------------------------------------------------------

    lab_top i_lab_top
    (
        .clk       ( clk       ),
        .slow_clk  ( slow_clk  ),
        .rst       ( rst       ),
        .key       ( key[1:0]  ),
        .mic       ( mic       ),
        .mic_valid ( mic_valid ),
        .sound     ( sound     ),
        .led       ( led       )
    );

    //------------------------------------------------------------------------

    i2s_audio_out
    #(
        .clk_mhz ( clk_mhz   )
    )
    inst_audio_out
    (
        .clk     ( clk       ),
        .reset   ( rst       ),
        .data_in ( sound     ),
        .mclk    ( i2s_mclk  ),
        .bclk    ( i2s_bclk  ),
        .sdata   ( i2s_sdata ),
        .lrclk   ( i2s_lrclk )
    );

endmodule

`default_nettype wire

// ==== verif/inmp441_model.sv ====
// Behavioral INMP441 microphone for simulation
// Shifts the given sample out on sd in the left half of each ws frame

`timescale 1ns/10ps
`default_nettype none

module inmp441_model
    import board_pkg::*;
(
    input  logic        rst,
    input  logic        sck,
    input  logic        ws,
    input  mic_sample_t sample,
    output logic        sd,
    output int          words_done
);

    mic_sample_t word;
    logic        ws_prev;
    int          pos;

    initial
    begin
        sd         = 1'b0;
        words_done = 0;
        word       = '0;
        ws_prev    = 1'b0;
        pos        = 0;
    end

    // The small delay lets ws settle after the sck edge
    always @(negedge sck)
    begin
        #2;
        if (rst)
        begin
            pos     = 0;
            ws_prev = 1'b0;
            sd      = 1'b0;
        end
        else
        begin
            // A falling ws starts the left half, MSB goes out one sck later
            if (!ws && ws_prev)
                pos = 0;
            else
                pos = pos + 1;

            if (!ws && pos == 1)
                word = sample;

            if (!ws && pos >= 1 && pos <= 24)
                sd = word[24 - pos];
            else
                sd = 1'b0;

            // Receiver has captured the last bit by now
            if (!ws && pos == 25)
                words_done = words_done + 1;

            ws_prev = ws;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_board_specific_top.sv ====
// Directed testbench for the audio board shell
// Drives a microphone model and decodes the DAC I2S stream back into words

`timescale 1ns/10ps
`default_nettype none

module tb_board_specific_top
    import board_pkg::*;
();

    localparam int clk_mhz      = 50;
    localparam int slow_clk_hz  = 1000;
    // Cycle limits for the waits
    localparam int slow_cycles  = clk_mhz * 1_000_000 / slow_clk_hz;
    localparam int frame_cycles = 600;
    localparam int mic_cycles   = 1200;

    logic          clk = 1'b0;
    logic [2:0]    key;
    wire           mic_sd;
    wire           mic_sck;
    wire           mic_ws;
    wire           i2s_mclk;
    wire           i2s_bclk;
    wire           i2s_lrclk;
    wire           i2s_sdata;
    led_bar_t      led;
    mic_sample_t   mic_value;
    int            mic_words;

    // Output decoder state
    logic [15:0]   rx_shift    = '0;
    logic          rx_lr_prev  = 1'b0;
    audio_sample_t left_word   = '0;
    audio_sample_t right_word  = '0;
    int            frame_count = 0;

    int unsigned   lcg_state;
    int            atten_exp;

    board_specific_top
    #(
        .clk_mhz     ( clk_mhz     ),
        .slow_clk_hz ( slow_clk_hz )
    )
    board_specific_top_inst
    (
        .clk       ( clk       ),
        .key       ( key       ),
        .mic_sd    ( mic_sd    ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .i2s_mclk  ( i2s_mclk  ),
        .i2s_bclk  ( i2s_bclk  ),
        .i2s_lrclk ( i2s_lrclk ),
        .i2s_sdata ( i2s_sdata ),
        .led       ( led       )
    );

    inmp441_model mic_model
    (
        .rst        ( key[2]    ),
        .sck        ( mic_sck   ),
        .ws         ( mic_ws    ),
        .sample     ( mic_value ),
        .sd         ( mic_sd    ),
        .words_done ( mic_words )
    );

    always #4 clk = ~clk;

    //------------------------------------------------------------------------
    // I2S decoder
    // The bit taken at the first rising bclk after an lrclk change is the
    // LSB of the previous half

    always @(posedge i2s_bclk)
    begin
        rx_shift = {rx_shift[14:0], i2s_sdata};
        if (i2s_lrclk != rx_lr_prev)
        begin
            if (rx_lr_prev)
            begin
                right_word  = rx_shift;
                frame_count = frame_count + 1;
            end
            else
            begin
                left_word = rx_shift;
            end
        end
        rx_lr_prev = i2s_lrclk;
    end

    //------------------------------------------------------------------------
    // Helpers

    function automatic mic_sample_t lcg_sample();
        logic [31:0] r;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        r         = lcg_state;
        return r[31:8];
    endfunction

    function automatic audio_sample_t expect_audio(mic_sample_t s, int atten);
        audio_sample_t top;
        top = s[23:8];
        return top >>> atten;
    endfunction

    // Thermometer of the top byte magnitude with bit 7 as the clip light
    function automatic led_bar_t expect_leds(mic_sample_t s);
        int       b;
        int       mag;
        led_bar_t pattern;
        b   = int'($signed(s[23:16]));
        mag = b < 0 ? -1 - b : b;
        for (int i = 0; i < 7; i++)
            pattern[i] = (mag >= (1 << i));
        pattern[7] = (mag == 127);
        return pattern;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_audio(string name, audio_sample_t got, audio_sample_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_leds(led_bar_t got, led_bar_t exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: led got %b expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pin(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic wait_frames(int n);
        int start;
        int cycles;
        start  = frame_count;
        cycles = 0;
        while (frame_count < start + n)
        begin
            next_cycle();
            cycles++;
            if (cycles > (n + 1) * frame_cycles)
            begin
                $display("timeout: no complete frame on the I2S output");
                abort_run();
            end
        end
    endtask

    task automatic wait_mic_words(int n);
        int start;
        int cycles;
        start  = mic_words;
        cycles = 0;
        while (mic_words < start + n)
        begin
            next_cycle();
            cycles++;
            if (cycles > (n + 1) * mic_cycles)
            begin
                $display("timeout: microphone clocks stopped, no sample was read");
                abort_run();
            end
        end
    endtask

    task automatic wait_leds(led_bar_t exp, int limit);
        int cycles;
        cycles = 0;
        while (led !== exp && cycles < limit)
        begin
            next_cycle();
            cycles++;
        end
        check_leds(led, exp);
    endtask

    task automatic press_key(int idx);
        key[idx] = 1'b1;
        repeat (4) next_cycle();
        key[idx] = 1'b0;
        repeat (4) next_cycle();
        if (idx == 0 && atten_exp < 7)
            atten_exp++;
        else if (idx == 1 && atten_exp > 0)
            atten_exp--;
    endtask

    // Sample must pass a whole mic frame, then reach the DAC
    task automatic play_and_check(mic_sample_t s);
        mic_value = s;
        wait_mic_words(2);
        wait_frames(3);
        check_audio("left word", left_word, expect_audio(s, atten_exp));
        check_audio("right word", right_word, expect_audio(s, atten_exp));
    endtask

    //------------------------------------------------------------------------
    // Tests

    task automatic test_reset();
        key = 3'b100;
        repeat (8) next_cycle();
        check_leds(led, 8'h00);
        check_pin("mic_sck", mic_sck, 1'b0);
        check_pin("mic_ws", mic_ws, 1'b0);
        check_pin("i2s_mclk", i2s_mclk, 1'b0);
        check_pin("i2s_bclk", i2s_bclk, 1'b0);
        check_pin("i2s_lrclk", i2s_lrclk, 1'b0);
        check_pin("i2s_sdata", i2s_sdata, 1'b0);
        key = 3'b000;
        wait_frames(1);
        check_audio("left word", left_word, '0);
        check_audio("right word", right_word, '0);
    endtask

    // mclk is the main clock divided by 4, so it changes every second cycle
    task automatic test_mclk();
        logic prev;
        int   cycles;
        prev   = i2s_mclk;
        cycles = 0;
        while (i2s_mclk === prev)
        begin
            next_cycle();
            cycles++;
            if (cycles > 8)
            begin
                $display("timeout: i2s_mclk does not toggle");
                abort_run();
            end
        end
        for (int i = 0; i < 16; i++)
        begin
            prev = i2s_mclk;
            next_cycle();
            check_pin("i2s_mclk", i2s_mclk, prev);
            next_cycle();
            check_pin("i2s_mclk", i2s_mclk, ~prev);
        end
    endtask

    task automatic test_loopback();
        mic_sample_t s;
        for (int i = 0; i < 6; i++)
        begin
            s     = lcg_sample();
            s[23] = i[0];
            play_and_check(s);
        end
    endtask

    task automatic test_volume();
        mic_sample_t s;
        s     = lcg_sample();
        s[23] = 1'b1;
        press_key(0);
        play_and_check(s);
        repeat (2) press_key(0);
        play_and_check(s);
        repeat (6) press_key(0);
        play_and_check(s);
        repeat (3) press_key(1);
        play_and_check(s);
        repeat (6) press_key(1);
        play_and_check(s);
    endtask

    task automatic test_meter_rise();
        logic [7:0]  tops [7];
        mic_sample_t s;
        tops = '{8'h01, 8'hFD, 8'h05, 8'hF7, 8'h20, 8'hBF, 8'h7F};
        // Let the peak decay from the louder earlier samples
        mic_value = '0;
        wait_leds(8'h00, 3 * slow_cycles);
        for (int i = 0; i < 7; i++)
        begin
            s         = lcg_sample();
            s[23:16]  = tops[i];
            mic_value = s;
            wait_mic_words(2);
            check_leds(led, expect_leds(s));
        end
    endtask

    task automatic test_meter_decay();
        mic_sample_t s;
        // Meter goes dark before the negative clip sample
        mic_value = '0;
        wait_leds(8'h00, 3 * slow_cycles);
        s         = lcg_sample();
        s[23:16]  = 8'h80;
        mic_value = s;
        wait_mic_words(2);
        check_leds(led, 8'hFF);
        s[23:16]  = 8'h06;
        mic_value = s;
        wait_leds(expect_leds(s), 3 * slow_cycles);
    endtask

    initial
    begin
        key       = 3'b100;
        mic_value = '0;
        lcg_state = 46;
        atten_exp = 0;
        test_reset();
        test_mclk();
        test_loopback();
        test_volume();
        test_meter_rise();
        test_meter_decay();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== board_audio.f ====
src/board_pkg.sv
src/slow_clk_gen.sv
src/inmp441_mic_i2s_receiver.sv
src/i2s_audio_out.sv
src/lab_top.sv
src/board_specific_top.sv
verif/inmp441_model.sv
verif/tb_board_specific_top.sv

// ==== Makefile ====
# Verilator build and run for the audio board shell

VERILATOR ?= verilator
TOP       ?= tb_board_specific_top
FILELIST  ?= board_audio.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
